//--- source/msg_pkg.sv
package msg_pkg;

	localparam logic [7:0] MARKER_SLAVE = 8'hA5;
	localparam logic [7:0] CMD_STATUS   = 8'h53;
	localparam logic [7:0] CMD_DATA     = 8'h44;
	localparam int         MSG_HDR_LEN  = 4;	// Marker, status, length high, length low.

	// Framer phase of a reply.
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_HDR  = 2'd1;
	localparam logic [1:0] ST_PL   = 2'd2;

	typedef struct packed {
		logic [2:0] rsvd_hi;
		logic       data_reply;
		logic       rsvd_3;
		logic       sd_busy;
		logic       tx_rdy;		// Enough payload for one data reply.
		logic       rx_err;
	} status_view_t;

	typedef struct packed {
		logic [2:0] rsvd_hi;
		logic       data_reply;
		logic       rsvd_3;
		logic       sd_busy;
		logic       has_next_dp;	// Another full payload is waiting.
		logic       rx_err;
	} data_view_t;

	typedef union packed {
		status_view_t s;
		data_view_t   d;
	} status_word_t;

endpackage

//--- source/link_cfg_pkg.sv
package link_cfg_pkg;

	localparam int unsigned S_DP_LEN = 8;	// Payload bytes per data reply.
	localparam int unsigned BIT_DIV  = 4;	// Clocks per serial bit.
	localparam int unsigned DP_DEPTH = 32;	// Power of two.

	// Buffer pointer and fill count widths.
	localparam int unsigned DP_PTR_W = $clog2(DP_DEPTH);
	localparam int unsigned DP_CNT_W = $clog2(DP_DEPTH + 1);

	// Framer byte counter, wide enough for header plus payload.
	localparam int unsigned BYTE_CNT_W = $clog2(S_DP_LEN + 8);

	// Serializer bit-period counter.
	localparam int unsigned BIT_CNT_W = $clog2(BIT_DIV + 1);

endpackage

//--- source/cmd_rx.sv
`timescale 1ns/1ps

module cmd_rx
	import msg_pkg::*;
(
	input  logic       clk,
	input  logic       n_rst,
	input  logic [7:0] rx_byte,
	input  logic       rx_byte_rdy,
	input  logic       rx_err,
	output logic       sd_s_req,
	output logic       sd_d_req,
	output logic       err_flag
);

	logic is_status;
	logic is_data;
	logic bad_strobe;

	assign is_status  = rx_byte == CMD_STATUS;
	assign is_data    = rx_byte == CMD_DATA;
	// Corrupted byte or unknown code.
	assign bad_strobe = rx_byte_rdy && (rx_err || !(is_status || is_data));

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			sd_s_req <= 1'b0;
			sd_d_req <= 1'b0;
		end
		else
		begin
			sd_s_req <= rx_byte_rdy && !rx_err && is_status;
			sd_d_req <= rx_byte_rdy && !rx_err && is_data;
		end
	end

	// Sticky until a request goes out; the framer still sees the old value then.
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			err_flag <= 1'b0;
		else if (bad_strobe)
			err_flag <= 1'b1;
		else if (sd_s_req || sd_d_req)
			err_flag <= 1'b0;
	end

	a_one_req: assert property (@(posedge clk) disable iff (!n_rst)
		!(sd_s_req && sd_d_req));

endmodule

//--- source/payload_buf.sv
`timescale 1ns/1ps

module payload_buf
	import link_cfg_pkg::*;
(
	input  logic       clk,
	input  logic       n_rst,
	input  logic [7:0] dp_byte,
	input  logic       dp_byte_rdy,
	input  logic       sd_d_ack,
	output logic [7:0] sd_d,
	output logic       sd_d_rdy,
	output logic       sd_d_tx_rdy,
	output logic       sd_has_next_dp,
	output logic       dp_full
);

	logic [7:0]          mem [DP_DEPTH];
	logic [DP_PTR_W-1:0] wr_ptr;
	logic [DP_PTR_W-1:0] rd_ptr;
	logic [DP_CNT_W-1:0] count;
	logic                push;
	logic                pop;

	assign push = dp_byte_rdy && !dp_full;	// Dropped when full.
	assign pop  = sd_d_ack && sd_d_rdy;

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= dp_byte;
	end

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Both in one cycle leave the count alone.
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	assign sd_d           = mem[rd_ptr];
	assign sd_d_rdy       = count != '0;
	assign sd_d_tx_rdy    = count >= DP_CNT_W'(S_DP_LEN);
	assign sd_has_next_dp = count >= DP_CNT_W'(2 * S_DP_LEN);
	assign dp_full        = count == DP_CNT_W'(DP_DEPTH);

	a_no_underflow: assert property (@(posedge clk) disable iff (!n_rst)
		sd_d_ack |-> sd_d_rdy);

	a_no_overflow: assert property (@(posedge clk) disable iff (!n_rst)
		dp_byte_rdy |-> !dp_full);

endmodule

//--- source/sdp_ctrl.sv
`timescale 1ns/1ps

module sdp_ctrl
	import msg_pkg::*;
	import link_cfg_pkg::*;
(
	input  logic       clk,
	input  logic       n_rst,
	input  logic       sd_s_req,
	input  logic       sd_d_req,
	input  logic       rx_err,
	input  logic       sd_d_tx_rdy,
	input  logic       sd_has_next_dp,
	input  logic       sd_busy,
	input  logic [7:0] sd_d,
	input  logic       sd_d_rdy,
	output logic       sd_d_ack,
	input  logic       cd_busy,
	input  logic       byte_taken,
	output logic [7:0] q,
	output logic       q_rdy,
	output logic       msg_end
);

	logic [1:0]            state;
	logic [BYTE_CNT_W-1:0] byte_cnt;
	logic                  is_data;	// Latched request type.
	logic                  err_l;
	logic                  start;
	logic                  hdr_done;
	logic                  frame_done;
	status_word_t          status;

	assign start      = (state == ST_IDLE) && (sd_s_req || sd_d_req);
	assign hdr_done   = byte_cnt == BYTE_CNT_W'(MSG_HDR_LEN);
	assign frame_done = byte_cnt == BYTE_CNT_W'(MSG_HDR_LEN + S_DP_LEN);

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			is_data <= 1'b0;
			err_l   <= 1'b0;
		end
		else if (start)
		begin
			is_data <= sd_d_req;
			err_l   <= rx_err;
		end
	end

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			state <= ST_IDLE;
		else
		begin
			case (state)
				ST_IDLE:
					if (start)
						state <= ST_HDR;
				ST_HDR:
					if (hdr_done && is_data)
						state <= ST_PL;	// Payload may queue behind the last header byte.
					else if (msg_end)
						state <= ST_IDLE;
				ST_PL:
					if (msg_end)
						state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			byte_cnt <= '0;
		else if (state == ST_IDLE)
			byte_cnt <= '0;
		else if (byte_taken)
			byte_cnt <= byte_cnt + 1'b1;
	end

	// Status byte, in the view of the reply being sent.
	always_comb
	begin
		status = '0;
		if (is_data)
		begin
			status.d.rx_err      = err_l;
			status.d.has_next_dp = sd_has_next_dp;
			status.d.sd_busy     = sd_busy;
			status.d.data_reply  = 1'b1;
		end
		else
		begin
			status.s.rx_err     = err_l;
			status.s.tx_rdy     = sd_d_tx_rdy;
			status.s.sd_busy    = sd_busy;
			status.s.data_reply = 1'b0;
		end
	end

	always_comb
	begin
		case (byte_cnt)
			BYTE_CNT_W'(0): q = MARKER_SLAVE;
			BYTE_CNT_W'(1): q = status;
			BYTE_CNT_W'(2): q = is_data ? 8'(S_DP_LEN >> 8) : 8'h00;
			BYTE_CNT_W'(3): q = is_data ? 8'(S_DP_LEN) : 8'h00;
			default:        q = sd_d;
		endcase
	end

	assign q_rdy = ((state == ST_HDR) && !hdr_done) ||
		((state == ST_PL) && sd_d_rdy && !frame_done);
	assign sd_d_ack = byte_taken && (state == ST_PL);

	// Last byte has left the line.
	assign msg_end = !cd_busy && (((state == ST_HDR) && !is_data && hdr_done) ||
		((state == ST_PL) && frame_done));

	a_state_legal: assert property (@(posedge clk) disable iff (!n_rst)
		state != 2'd3);

endmodule

//--- source/byte_ser.sv
`timescale 1ns/1ps

module byte_ser
	import link_cfg_pkg::*;
(
	input  logic       clk,
	input  logic       n_rst,
	input  logic [7:0] q,
	input  logic       q_rdy,
	output logic       byte_taken,
	output logic       cd_busy,
	output logic       tx_line
);

	logic [9:0]           frame;	// Stop, data, start.
	logic [BIT_CNT_W-1:0] div_cnt;
	logic [3:0]           bit_idx;
	logic                 bit_end;

	assign byte_taken = q_rdy && !cd_busy;
	assign bit_end    = div_cnt == BIT_CNT_W'(BIT_DIV - 1);

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			cd_busy <= 1'b0;
			div_cnt <= '0;
			bit_idx <= '0;
		end
		else if (byte_taken)
		begin
			cd_busy <= 1'b1;
			div_cnt <= '0;
			bit_idx <= '0;
		end
		else if (cd_busy)
		begin
			if (bit_end)
			begin
				div_cnt <= '0;
				if (bit_idx == 4'd9)
					cd_busy <= 1'b0;	// End of stop bit.
				else
					bit_idx <= bit_idx + 1'b1;
			end
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (byte_taken)
			frame <= {1'b1, q, 1'b0};
		else if (cd_busy && bit_end)
			frame <= {1'b1, frame[9:1]};	// LSB first.
	end

	assign tx_line = cd_busy ? frame[0] : 1'b1;

	a_no_load_busy: assert property (@(posedge clk) disable iff (!n_rst)
		cd_busy |-> !byte_taken);

endmodule

//--- source/slave_link.sv
`timescale 1ns/1ps

module slave_link (
	input  logic       clk,
	input  logic       n_rst,
	input  logic [7:0] rx_byte,
	input  logic       rx_byte_rdy,
	input  logic       rx_err,
	input  logic [7:0] dp_byte,
	input  logic       dp_byte_rdy,
	input  logic       sd_busy,
	output logic       tx_line,
	output logic       msg_end,
	output logic       dp_full
);

	logic       sd_s_req;
	logic       sd_d_req;
	logic       err_flag;
	logic [7:0] sd_d;
	logic       sd_d_rdy;
	logic       sd_d_tx_rdy;
	logic       sd_has_next_dp;
	logic       sd_d_ack;
	logic [7:0] q;
	logic       q_rdy;
	logic       byte_taken;
	logic       cd_busy;

	cmd_rx i_cmd_rx (
		.clk, .n_rst, .rx_byte, .rx_byte_rdy, .rx_err,
		.sd_s_req, .sd_d_req, .err_flag
	);

	payload_buf i_payload_buf (
		.clk, .n_rst, .dp_byte, .dp_byte_rdy, .sd_d_ack,
		.sd_d, .sd_d_rdy, .sd_d_tx_rdy, .sd_has_next_dp, .dp_full
	);

	sdp_ctrl i_sdp_ctrl (
		.clk, .n_rst, .sd_s_req, .sd_d_req,
		.rx_err (err_flag),	// Sticky flag, not the raw strobe qualifier.
		.sd_d_tx_rdy, .sd_has_next_dp, .sd_busy, .sd_d, .sd_d_rdy, .sd_d_ack,
		.cd_busy, .byte_taken, .q, .q_rdy, .msg_end
	);

	byte_ser i_byte_ser (
		.clk, .n_rst, .q, .q_rdy, .byte_taken, .cd_busy, .tx_line
	);

endmodule

//--- tests/slave_link_tb.sv
`timescale 1ns/1ps

module slave_link_tb
	import msg_pkg::*;
	import link_cfg_pkg::*;
();

	localparam int CLK_NS      = 40;
	localparam int BIT_NS      = BIT_DIV * CLK_NS;
	// Seven status replies and three data replies in the run.
	localparam int TOTAL_BYTES = 7 * MSG_HDR_LEN + 3 * (MSG_HDR_LEN + S_DP_LEN);
	localparam longint WATCHDOG_NS = 2 * TOTAL_BYTES * 10 * BIT_DIV * CLK_NS;

	logic       clk;
	logic       n_rst;
	logic [7:0] rx_byte;
	logic       rx_byte_rdy;
	logic       rx_err;
	logic [7:0] dp_byte;
	logic       dp_byte_rdy;
	logic       sd_busy;
	wire        tx_line;
	wire        msg_end;
	wire        dp_full;

	int         err_cnt = 0;
	int         test_cnt = 0;
	int         test_bad_cnt = 0;
	int         msg_cnt = 0;
	int         seed = 32'had46;
	logic [7:0] line_data;
	logic [7:0] rx_q[$];	// Bytes seen on tx_line.
	logic [7:0] exp_q[$];	// Bytes pushed into the buffer.

	slave_link i_slave_link (
		.clk, .n_rst, .rx_byte, .rx_byte_rdy, .rx_err,
		.dp_byte, .dp_byte_rdy, .sd_busy, .tx_line, .msg_end, .dp_full
	);

	initial clk = 1'b0;
	always #(CLK_NS / 2) clk = ~clk;

	always @(negedge clk)
	begin
		if (msg_end === 1'b1)
			msg_cnt++;
	end

	// Serial line decoder sampling near the middle of each bit.
	always
	begin
		@(negedge tx_line);
		#(BIT_NS / 2 + CLK_NS / 4);
		if (tx_line !== 1'b0)
		begin
			$display("Line decoder: start bit did not stay low at %0t ns", $time);
			err_cnt++;
		end
		else
		begin
			for (int i = 0; i < 8; i++)
			begin
				#(BIT_NS);
				line_data[i] = tx_line;
			end
			#(BIT_NS);
			if (tx_line !== 1'b1)
			begin
				$display("Line decoder: stop bit missing at %0t ns", $time);
				err_cnt++;
			end
			rx_q.push_back(line_data);
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog: the run took longer than %0d ns and was stopped", WATCHDOG_NS);
		$display("test failed");
		$finish;
	end

	function automatic int frame_cycles(input int n_bytes);
		return n_bytes * (10 * BIT_DIV + 1) + 10;
	endfunction

	function automatic status_word_t status_reply_word(input logic err, input logic rdy,
		input logic busy);
		status_word_t w;
		w = '0;
		w.s.rx_err  = err;
		w.s.tx_rdy  = rdy;
		w.s.sd_busy = busy;
		return w;
	endfunction

	function automatic status_word_t data_reply_word(input logic err, input logic next,
		input logic busy);
		status_word_t w;
		w = '0;
		w.d.rx_err      = err;
		w.d.has_next_dp = next;
		w.d.sd_busy     = busy;
		w.d.data_reply  = 1'b1;
		return w;
	endfunction

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_status(input string what, input status_word_t got,
		input status_word_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t ns: %s is %h (err %b bit1 %b busy %b data %b), expected %h",
				$time, what, got, got.s.rx_err, got.s.tx_rdy, got.s.sd_busy,
				got.s.data_reply, exp);
			err_cnt++;
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#2;
		n_rst = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		rx_q.delete();
		exp_q.delete();
		n_rst = 1'b1;
	endtask

	task automatic send_cmd(input logic [7:0] code, input logic err);
		@(posedge clk);
		#2;
		rx_byte     = code;
		rx_err      = err;
		rx_byte_rdy = 1'b1;
		@(posedge clk);
		#2;
		rx_byte_rdy = 1'b0;
		rx_err      = 1'b0;
	endtask

	task automatic push_random(input int n);
		logic [7:0] val;
		for (int i = 0; i < n; i++)
		begin
			val = 8'($random(seed));
			@(posedge clk);
			#2;
			dp_byte     = val;
			dp_byte_rdy = 1'b1;
			exp_q.push_back(val);
			@(posedge clk);
			#2;
			dp_byte_rdy = 1'b0;
		end
	endtask

	task automatic wait_msg_end(input int max_cyc);
		int start;
		int n;
		start = msg_cnt;
		n = 0;
		while (msg_cnt == start && n < max_cyc)
		begin
			@(negedge clk);
			n++;
		end
		if (msg_cnt == start)
		begin
			$display("Timeout: no end of message within %0d cycles at %0t ns", max_cyc, $time);
			err_cnt++;
		end
	endtask

	task automatic wait_rx_bytes(input int n_bytes, input int max_cyc);
		int n;
		n = 0;
		while (rx_q.size() < n_bytes && n < max_cyc)
		begin
			@(negedge clk);
			n++;
		end
		if (rx_q.size() < n_bytes)
		begin
			$display("Timeout: only %0d of %0d bytes arrived at %0t ns",
				rx_q.size(), n_bytes, $time);
			err_cnt++;
		end
	endtask

	// Header fields and then payload against the pushed bytes.
	task automatic check_frame(input status_word_t exp_st, input int n_pl);
		if (rx_q.size() != MSG_HDR_LEN + n_pl || exp_q.size() < n_pl)
		begin
			$display("Frame has %0d bytes, expected %0d, at %0t ns", rx_q.size(), MSG_HDR_LEN + n_pl,
				$time);
			err_cnt++;
		end
		else
		begin
			check_byte("marker", rx_q[0], MARKER_SLAVE);
			check_status("status byte", rx_q[1], exp_st);
			check_byte("length high", rx_q[2], 8'(n_pl >> 8));
			check_byte("length low", rx_q[3], 8'(n_pl));
			for (int i = 0; i < n_pl; i++)
				check_byte("payload byte", rx_q[MSG_HDR_LEN + i], exp_q.pop_front());
		end
		rx_q.delete();
	endtask

	task automatic request_status(input status_word_t exp_st);
		send_cmd(CMD_STATUS, 1'b0);
		wait_msg_end(frame_cycles(MSG_HDR_LEN));
		check_frame(exp_st, 0);
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_cnt++;
		if (err_cnt == errs_before)
			$display("%s: ok", name);
		else
		begin
			test_bad_cnt++;
			$display("%s: %0d error(s)", name, err_cnt - errs_before);
		end
	endtask

	task automatic reset_then_status();
		int e0;
		int m0;
		e0 = err_cnt;
		apply_reset();
		repeat (20)
		begin
			@(negedge clk);
			check_bit("idle tx_line", tx_line, 1'b1);
			check_bit("idle msg_end", msg_end, 1'b0);
		end
		m0 = msg_cnt;
		request_status(status_reply_word(1'b0, 1'b0, 1'b0));
		repeat (10) @(negedge clk);
		check_byte("msg_end pulse count", 8'(msg_cnt - m0), 8'd1);
		report_test("status after reset", e0);
	endtask

	task automatic status_with_busy();
		int e0;
		e0 = err_cnt;
		apply_reset();
		push_random(S_DP_LEN);
		@(posedge clk);
		#2;
		sd_busy = 1'b1;
		request_status(status_reply_word(1'b0, 1'b1, 1'b1));
		check_bit("dp_full", dp_full, 1'b0);
		@(posedge clk);
		#2;
		sd_busy = 1'b0;
		report_test("status with ready payload and busy sensor", e0);
	endtask

	task automatic data_replies();
		int e0;
		e0 = err_cnt;
		apply_reset();
		push_random(2 * S_DP_LEN);
		send_cmd(CMD_DATA, 1'b0);
		wait_msg_end(frame_cycles(MSG_HDR_LEN + S_DP_LEN));
		check_frame(data_reply_word(1'b0, 1'b1, 1'b0), S_DP_LEN);
		send_cmd(CMD_DATA, 1'b0);
		wait_msg_end(frame_cycles(MSG_HDR_LEN + S_DP_LEN));
		check_frame(data_reply_word(1'b0, 1'b0, 1'b0), S_DP_LEN);
		report_test("two data replies", e0);
	endtask

	task automatic error_flag_cycle();
		int e0;
		e0 = err_cnt;
		apply_reset();
		send_cmd(8'h7E, 1'b0);	// Unknown code.
		request_status(status_reply_word(1'b1, 1'b0, 1'b0));
		request_status(status_reply_word(1'b0, 1'b0, 1'b0));
		send_cmd(CMD_STATUS, 1'b1);	// Valid code with a corrupted strobe.
		repeat (10)
		begin
			@(negedge clk);
			check_bit("tx_line after corrupted command", tx_line, 1'b1);
		end
		request_status(status_reply_word(1'b1, 1'b0, 1'b0));
		request_status(status_reply_word(1'b0, 1'b0, 1'b0));
		report_test("sticky receive error", e0);
	endtask

	task automatic empty_buffer_stall();
		int e0;
		int m0;
		e0 = err_cnt;
		apply_reset();
		m0 = msg_cnt;
		send_cmd(CMD_DATA, 1'b0);
		wait_rx_bytes(MSG_HDR_LEN, frame_cycles(MSG_HDR_LEN));
		repeat (4) @(negedge clk);
		repeat (60)
		begin
			@(negedge clk);
			check_bit("stalled tx_line", tx_line, 1'b1);
			check_bit("stalled msg_end", msg_end, 1'b0);
		end
		check_byte("msg_end pulse count", 8'(msg_cnt - m0), 8'd0);
		push_random(S_DP_LEN);
		wait_msg_end(frame_cycles(S_DP_LEN));
		check_frame(data_reply_word(1'b0, 1'b0, 1'b0), S_DP_LEN);
		report_test("data reply from empty buffer", e0);
	endtask

	task automatic drop_and_fill();
		int e0;
		int m0;
		e0 = err_cnt;
		apply_reset();
		m0 = msg_cnt;
		send_cmd(CMD_STATUS, 1'b0);
		repeat (10) @(negedge clk);
		send_cmd(CMD_DATA, 1'b0);	// Lands mid reply.
		wait_msg_end(frame_cycles(MSG_HDR_LEN));
		repeat (frame_cycles(2)) @(negedge clk);
		check_byte("msg_end pulse count", 8'(msg_cnt - m0), 8'd1);
		check_frame(status_reply_word(1'b0, 1'b0, 1'b0), 0);
		push_random(DP_DEPTH - 1);
		@(negedge clk);
		check_bit("dp_full one short", dp_full, 1'b0);
		push_random(1);
		@(negedge clk);
		check_bit("dp_full", dp_full, 1'b1);
		report_test("dropped command and full buffer", e0);
	endtask

	initial
	begin
		n_rst       = 1'b0;
		rx_byte     = 8'h00;
		rx_byte_rdy = 1'b0;
		rx_err      = 1'b0;
		dp_byte     = 8'h00;
		dp_byte_rdy = 1'b0;
		sd_busy     = 1'b0;
		reset_then_status();
		status_with_busy();
		data_replies();
		error_flag_cycle();
		empty_buffer_stall();
		drop_and_fill();
		$display("Tests run %0d, with errors %0d, error lines %0d",
			test_cnt, test_bad_cnt, err_cnt);
		if (err_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- slave_link.f
source/msg_pkg.sv
source/link_cfg_pkg.sv
source/cmd_rx.sv
source/payload_buf.sv
source/sdp_ctrl.sv
source/byte_ser.sv
source/slave_link.sv
tests/slave_link_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 \
	--top-module slave_link_tb -f slave_link.f -o slave_link_sim > build.log 2>&1 \
	|| { cat build.log; echo "Build error, see build.log"; exit 1; }

./obj_dir/slave_link_sim > sim.log 2>&1 ; cat sim.log

grep -qx "test passed" sim.log && echo "Simulation PASS" \
	|| { echo "Simulation FAIL, see sim.log"; exit 1; }
